// File: Bender.yml
package:
  name: lr35902_snd

sources:
  - hw/snd_pkg.sv
  - hw/snd_regs.sv
  - hw/frame_sequencer.sv
  - hw/pulse_voice.sv
  - hw/snd_mixer.sv
  - hw/lr35902_snd.sv
  - target: test
    files:
      - test/snd_checker.sv
      - test/snd_monitor.sv
      - test/snd_tb.sv

// File: hw/frame_sequencer.sv
module frame_sequencer (
	input  logic clk,
	input  logic reset,
	output logic freq_tick,
	output logic len_clk,
	output logic env_clk
);

	localparam int TICK_BITS = $clog2(snd_pkg::TICK_DIV);

	logic [snd_pkg::PRESCALE_W-1:0] prescale;
	logic [2:0]                     step; // frame step, eight per envelope period.
	logic                           frame_end;

	always_ff @(posedge clk) begin
		if (reset) begin
			prescale <= '0;
			step     <= '0;
		end else begin
			prescale <= prescale + 1'b1;
			if (frame_end)
				step <= step + 1'b1;
		end
	end

	assign frame_end = &prescale; // once every 8192 clocks.

	// the frequency counters advance at a quarter of the clock rate.
	assign freq_tick = &prescale[TICK_BITS-1:0];

	// length runs on the even steps and the envelope on the last step.
	assign len_clk = frame_end && !step[0];
	assign env_clk = frame_end && (&step);

endmodule

// File: hw/lr35902_snd.sv
module lr35902_snd (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [snd_pkg::ADR_W-1:0]   adr,
	input  logic [snd_pkg::DATA_W-1:0]  din,
	input  logic                        read,
	input  logic                        write,
	output logic [snd_pkg::DATA_W-1:0]  dout,
	output logic [snd_pkg::LEVEL_W-1:0] so1_level,
	output logic [snd_pkg::LEVEL_W-1:0] so2_level
);

	logic [1:0]                     v1_duty, v2_duty;
	logic [snd_pkg::LEN_W-1:0]      v1_len, v2_len;
	logic [snd_pkg::VOL_W-1:0]      v1_vol_init, v2_vol_init;
	logic                           v1_vol_inc, v2_vol_inc;
	logic [snd_pkg::ENV_TIME_W-1:0] v1_vol_time, v2_vol_time;
	logic [snd_pkg::FREQ_W-1:0]     v1_freq, v2_freq;
	logic                           v1_len_ena, v2_len_ena;
	logic                           v1_trigger, v2_trigger;
	logic                           v1_len_load, v2_len_load;
	logic                           v1_active, v2_active;
	logic [snd_pkg::VOL_W-1:0]      v1_level, v2_level;
	logic [3:0]                     route;
	logic                           master_on;
	logic                           freq_tick, len_clk, env_clk;

	snd_regs u_regs (
		.clk, .reset, .adr, .din, .read, .write, .v1_active, .v2_active, .dout,
		.v1_duty, .v1_len, .v1_vol_init, .v1_vol_inc, .v1_vol_time, .v1_freq,
		.v1_len_ena, .v1_trigger, .v1_len_load,
		.v2_duty, .v2_len, .v2_vol_init, .v2_vol_inc, .v2_vol_time, .v2_freq,
		.v2_len_ena, .v2_trigger, .v2_len_load,
		.route, .master_on
	);

	frame_sequencer u_seq (.clk, .reset, .freq_tick, .len_clk, .env_clk);

	pulse_voice u_voice1 (
		.clk, .reset, .freq_tick, .len_clk, .env_clk,
		.duty(v1_duty), .len(v1_len), .vol_init(v1_vol_init), .vol_inc(v1_vol_inc),
		.vol_time(v1_vol_time), .freq(v1_freq), .len_ena(v1_len_ena),
		.trigger(v1_trigger), .len_load(v1_len_load), .active(v1_active), .level(v1_level)
	);

	pulse_voice u_voice2 (
		.clk, .reset, .freq_tick, .len_clk, .env_clk,
		.duty(v2_duty), .len(v2_len), .vol_init(v2_vol_init), .vol_inc(v2_vol_inc),
		.vol_time(v2_vol_time), .freq(v2_freq), .len_ena(v2_len_ena),
		.trigger(v2_trigger), .len_load(v2_len_load), .active(v2_active), .level(v2_level)
	);

	snd_mixer u_mixer (
		.clk, .reset, .master_on, .route, .v1_level, .v2_level, .so1_level, .so2_level
	);

endmodule

// File: hw/pulse_voice.sv
module pulse_voice (
	input  logic                           clk,
	input  logic                           reset,
	input  logic                           freq_tick,
	input  logic                           len_clk,
	input  logic                           env_clk,
	input  logic [1:0]                     duty,
	input  logic [snd_pkg::LEN_W-1:0]      len,
	input  logic [snd_pkg::VOL_W-1:0]      vol_init,
	input  logic                           vol_inc,
	input  logic [snd_pkg::ENV_TIME_W-1:0] vol_time,
	input  logic [snd_pkg::FREQ_W-1:0]     freq,
	input  logic                           len_ena,
	input  logic                           trigger,
	input  logic                           len_load,
	output logic                           active,
	output logic [snd_pkg::VOL_W-1:0]      level
);

	logic [snd_pkg::FREQ_W-1:0]     freq_cnt;
	logic [2:0]                     duty_step;
	logic [snd_pkg::ENV_TIME_W-1:0] env_cnt;
	logic [snd_pkg::LEN_W:0]        len_cnt; // bit 6 set means the length has run out.
	logic [snd_pkg::VOL_W-1:0]      vol;
	logic                           wave_high;

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			freq_cnt  <= '0;
			duty_step <= '0;
			env_cnt   <= '0;
			len_cnt   <= '0;
			vol       <= '0;
		end else if (trigger) begin
			active    <= 1'b1;
			freq_cnt  <= freq;
			duty_step <= '0;
			env_cnt   <= '0;
			len_cnt   <= {1'b0, len};
			vol       <= vol_init;
		end else begin
			if (freq_tick && active) begin
				freq_cnt <= freq_cnt + 1'b1;
				if (&freq_cnt) begin
					freq_cnt  <= freq;
					duty_step <= duty_step + 1'b1;
				end
			end
			if (env_clk && active && vol_time != '0) begin
				env_cnt <= env_cnt + 1'b1;
				if (env_cnt + 1'b1 == vol_time) begin
					env_cnt <= '0;
					if (vol_inc && !(&vol))
						vol <= vol + 1'b1;
					else if (!vol_inc && vol != '0)
						vol <= vol - 1'b1;
				end
			end
			if (len_clk && active && len_ena) begin
				len_cnt <= len_cnt + 1'b1;
				if (len_cnt[snd_pkg::LEN_W]) begin
					len_cnt <= {1'b0, len};
					active  <= 1'b0;
				end
			end
			if (len_load)
				len_cnt <= {1'b0, len}; // a length write wins over a length clock.
		end
	end

	always_comb begin
		case (duty)
		2'd0:    wave_high = duty_step >= 3'd1; // 12.5 percent low.
		2'd1:    wave_high = duty_step >= 3'd2;
		2'd2:    wave_high = duty_step >= 3'd4;
		default: wave_high = duty_step >= 3'd6;
		endcase
	end

	// the swing around the idle level is half the volume, rounded down above and up below.
	always_comb begin
		if (!active)
			level = snd_pkg::VOICE_IDLE;
		else if (wave_high)
			level = snd_pkg::VOICE_IDLE + vol[snd_pkg::VOL_W-1:1];
		else
			level = snd_pkg::VOICE_IDLE - vol[snd_pkg::VOL_W-1:1] - vol[0];
	end

endmodule

// File: hw/snd_mixer.sv
module snd_mixer (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        master_on,
	input  logic [3:0]                  route,
	input  logic [snd_pkg::VOL_W-1:0]   v1_level,
	input  logic [snd_pkg::VOL_W-1:0]   v2_level,
	output logic [snd_pkg::LEVEL_W-1:0] so1_level,
	output logic [snd_pkg::LEVEL_W-1:0] so2_level
);

	logic [snd_pkg::LEVEL_W-1:0] so1_sum;
	logic [snd_pkg::LEVEL_W-1:0] so2_sum;

	// an unrouted voice contributes its idle level so the sides stay centred.
	assign so1_sum = (route[0] ? v1_level : snd_pkg::VOICE_IDLE)
		+ (route[1] ? v2_level : snd_pkg::VOICE_IDLE)
		+ snd_pkg::DROPPED_LEVEL;
	assign so2_sum = (route[2] ? v1_level : snd_pkg::VOICE_IDLE)
		+ (route[3] ? v2_level : snd_pkg::VOICE_IDLE)
		+ snd_pkg::DROPPED_LEVEL;

	always_ff @(posedge clk) begin
		if (reset || !master_on) begin
			so1_level <= snd_pkg::MIX_IDLE;
			so2_level <= snd_pkg::MIX_IDLE;
		end else begin
			so1_level <= so1_sum;
			so2_level <= so2_sum; // peaks at 46 with both voices at full volume.
		end
	end

endmodule

// File: hw/snd_pkg.sv
package snd_pkg;

	// cpu bus.
	localparam int ADR_W  = 6;
	localparam int DATA_W = 8;

	// register map of the kept voices and the global controls.
	localparam logic [ADR_W-1:0] NR11 = 6'h11; // voice 1 duty and length.
	localparam logic [ADR_W-1:0] NR12 = 6'h12; // voice 1 envelope.
	localparam logic [ADR_W-1:0] NR13 = 6'h13; // voice 1 frequency low byte.
	localparam logic [ADR_W-1:0] NR14 = 6'h14; // voice 1 control and frequency high bits.
	localparam logic [ADR_W-1:0] NR21 = 6'h16;
	localparam logic [ADR_W-1:0] NR22 = 6'h17;
	localparam logic [ADR_W-1:0] NR23 = 6'h18;
	localparam logic [ADR_W-1:0] NR24 = 6'h19;
	localparam logic [ADR_W-1:0] NR51 = 6'h25; // channel select per side.
	localparam logic [ADR_W-1:0] NR52 = 6'h26; // master enable and voice status.

	// voice field widths.
	localparam int FREQ_W     = 11;
	localparam int LEN_W      = 6;
	localparam int VOL_W      = 4;
	localparam int ENV_TIME_W = 3;

	// mix level per side.
	localparam int LEVEL_W = 6;

	// timing of the frame sequencer.
	localparam int PRESCALE_W = 13; // all ones marks one frame step.
	localparam int TICK_DIV   = 4;  // clocks per frequency tick.

	// a silent voice sits in the middle of its 4-bit range.
	localparam logic [VOL_W-1:0] VOICE_IDLE = 4'd8;

	// the two slots of the voices that no longer exist still add their idle level.
	localparam logic [LEVEL_W-1:0] DROPPED_LEVEL = 6'd16;

	// level of each side while the master enable is off.
	localparam logic [LEVEL_W-1:0] MIX_IDLE = 6'd32;

endpackage

// File: hw/snd_regs.sv
module snd_regs (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [snd_pkg::ADR_W-1:0]     adr,
	input  logic [snd_pkg::DATA_W-1:0]    din,
	input  logic                          read,
	input  logic                          write,
	input  logic                          v1_active,
	input  logic                          v2_active,
	output logic [snd_pkg::DATA_W-1:0]    dout,
	output logic [1:0]                    v1_duty,
	output logic [snd_pkg::LEN_W-1:0]     v1_len,
	output logic [snd_pkg::VOL_W-1:0]     v1_vol_init,
	output logic                          v1_vol_inc,
	output logic [snd_pkg::ENV_TIME_W-1:0] v1_vol_time,
	output logic [snd_pkg::FREQ_W-1:0]    v1_freq,
	output logic                          v1_len_ena,
	output logic                          v1_trigger,
	output logic                          v1_len_load,
	output logic [1:0]                    v2_duty,
	output logic [snd_pkg::LEN_W-1:0]     v2_len,
	output logic [snd_pkg::VOL_W-1:0]     v2_vol_init,
	output logic                          v2_vol_inc,
	output logic [snd_pkg::ENV_TIME_W-1:0] v2_vol_time,
	output logic [snd_pkg::FREQ_W-1:0]    v2_freq,
	output logic                          v2_len_ena,
	output logic                          v2_trigger,
	output logic                          v2_len_load,
	output logic [3:0]                    route,
	output logic                          master_on
);

	logic                          v1_trig_req; // trigger write seen, pulse follows next edge.
	logic                          v2_trig_req;
	logic [snd_pkg::DATA_W-1:0]    rdata;

	always_ff @(posedge clk) begin
		if (reset) begin
			{v1_duty, v1_len, v1_vol_init, v1_vol_inc, v1_vol_time} <= '0;
			{v2_duty, v2_len, v2_vol_init, v2_vol_inc, v2_vol_time} <= '0;
			{v1_freq, v1_len_ena, v2_freq, v2_len_ena} <= '0;
			{v1_trig_req, v2_trig_req, v1_trigger, v2_trigger} <= '0;
			{v1_len_load, v2_len_load} <= '0;
			route     <= '0;
			master_on <= 1'b0;
		end else begin
			v1_trigger  <= v1_trig_req; // the voice sees the new frequency by now.
			v2_trigger  <= v2_trig_req;
			v1_trig_req <= 1'b0;
			v2_trig_req <= 1'b0;
			v1_len_load <= 1'b0;
			v2_len_load <= 1'b0;
			if (write && master_on) begin
				case (adr)
				snd_pkg::NR11: begin
					{v1_duty, v1_len} <= din;
					v1_len_load       <= 1'b1; // restart the length count.
				end
				snd_pkg::NR12: {v1_vol_init, v1_vol_inc, v1_vol_time} <= din;
				snd_pkg::NR13: v1_freq[7:0] <= din;
				snd_pkg::NR14: begin
					v1_freq[10:8] <= din[2:0];
					v1_len_ena    <= din[6];
					v1_trig_req   <= din[7];
				end
				snd_pkg::NR21: begin
					{v2_duty, v2_len} <= din;
					v2_len_load       <= 1'b1;
				end
				snd_pkg::NR22: {v2_vol_init, v2_vol_inc, v2_vol_time} <= din;
				snd_pkg::NR23: v2_freq[7:0] <= din;
				snd_pkg::NR24: begin
					v2_freq[10:8] <= din[2:0];
					v2_len_ena    <= din[6];
					v2_trig_req   <= din[7];
				end
				snd_pkg::NR51: route <= {din[5:4], din[1:0]}; // slots of the dropped voices are not kept.
				snd_pkg::NR52: master_on <= din[7];
				default: ;
				endcase
			end else if (write && adr == snd_pkg::NR52 && din[7]) begin
				master_on <= 1'b1; // the only write accepted while the unit is off.
			end
		end
	end

	always_comb begin
		case (adr)
		snd_pkg::NR11: rdata = {v1_duty, v1_len};
		snd_pkg::NR12: rdata = {v1_vol_init, v1_vol_inc, v1_vol_time};
		snd_pkg::NR14: rdata = {1'b1, v1_len_ena, 6'h3f};
		snd_pkg::NR21: rdata = {v2_duty, v2_len};
		snd_pkg::NR22: rdata = {v2_vol_init, v2_vol_inc, v2_vol_time};
		snd_pkg::NR24: rdata = {1'b1, v2_len_ena, 6'h3f};
		snd_pkg::NR51: rdata = {2'b11, route[3:2], 2'b11, route[1:0]};
		snd_pkg::NR52: rdata = {master_on, 5'h1f, v2_active, v1_active};
		default:       rdata = 8'hff; // frequency bytes are write only.
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			dout <= '0;
		else if (read)
			dout <= rdata; // held until the next read strobe.
	end

endmodule

// File: tb.f
hw/snd_pkg.sv
hw/snd_regs.sv
hw/frame_sequencer.sv
hw/pulse_voice.sv
hw/snd_mixer.sv
hw/lr35902_snd.sv
test/snd_checker.sv
test/snd_monitor.sv
test/snd_tb.sv

// File: test/snd_checker.sv
module snd_checker (
	input logic                        clk,
	input logic                        reset,
	input logic                        read,
	input logic                        write,
	input logic                        master_on,
	input logic [snd_pkg::LEVEL_W-1:0] so1_level,
	input logic [snd_pkg::LEVEL_W-1:0] so2_level
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0; // collected by the testbench top at the end of the run.

	// two voices swing 0 to 15 each, on top of the two idle dropped slots.
	level_range: assert property (@(posedge clk) disable iff (reset)
		master_on |-> (so1_level inside {[16:46]} && so2_level inside {[16:46]}))
		else begin
			fail_count++;
			$error("mix level left the range 16 to 46 while the unit was on");
		end

	idle_when_off: assert property (@(posedge clk) disable iff (reset)
		!master_on |=> (so1_level == snd_pkg::MIX_IDLE && so2_level == snd_pkg::MIX_IDLE))
		else begin
			fail_count++;
			$error("mix level not idle one cycle after the unit was switched off");
		end

	no_read_with_write: assert property (@(posedge clk) disable iff (reset) !(read && write))
		else begin
			fail_count++;
			$error("read and write strobes were high in the same cycle");
		end

endmodule

bind lr35902_snd snd_checker u_chk (
	.clk, .reset, .read, .write, .master_on, .so1_level, .so2_level
);

// File: test/snd_monitor.sv
module snd_monitor (
	input logic                        clk,
	input logic                        reset,
	input logic [snd_pkg::ADR_W-1:0]   adr,
	input logic [snd_pkg::DATA_W-1:0]  din,
	input logic                        read,
	input logic                        write,
	input logic [snd_pkg::DATA_W-1:0]  dout,
	input logic [snd_pkg::LEVEL_W-1:0] so1_level,
	input logic [snd_pkg::LEVEL_W-1:0] so2_level
);
	timeunit 1ns;
	timeprecision 1ps;

	int         tests_run = 0;
	int         tests_failed = 0;
	int         reads_done = 0;
	int         errors = 0;
	string      test_name;
	logic       master;
	logic [7:0] nr11, nr12, nr14, nr21, nr22, nr24, nr51; // last accepted writes.
	logic [1:0] act_care = '0; // which NR52 status bits a read has to match.
	logic [1:0] act_exp = '0;
	logic       rd_pending;
	logic [7:0] rd_exp, rd_mask;
	logic [5:0] rd_adr;
	int         lo1, hi1, lo2, hi2, peak;

	function automatic logic [7:0] expected_read(input logic [5:0] a);
		case (a)
		snd_pkg::NR11: return nr11;
		snd_pkg::NR12: return nr12;
		snd_pkg::NR14: return {1'b1, nr14[6], 6'h3f};
		snd_pkg::NR21: return nr21;
		snd_pkg::NR22: return nr22;
		snd_pkg::NR24: return {1'b1, nr24[6], 6'h3f};
		snd_pkg::NR51: return {2'b11, nr51[5:4], 2'b11, nr51[1:0]};
		snd_pkg::NR52: return {master, 5'h1f, act_exp};
		default:       return 8'hff;
		endcase
	endfunction

	// a routed voice swings floor(vol/2) above and ceil(vol/2) below the idle level.
	function automatic int slot_level(input logic routed, input int vol, input logic high);
		int idle;
		idle = snd_pkg::VOICE_IDLE;
		if (!routed)
			return idle;
		return high ? idle + vol / 2 : idle - (vol + 1) / 2;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic timeout_seen(input string what);
		errors++;
		$display("timeout: %s", what);
	endtask

	task automatic compare_level(input string what, input int got, input int exp);
		if (got != exp)
			report_error($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors = 0;
		peak = 64;
		act_care = '0;
		act_exp = '0;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == 0) begin
			$display("PASS %s", test_name);
		end else begin
			tests_failed++;
			$display("FAIL %0t: %s with %0d errors", $time, test_name, errors);
		end
	endtask

	task automatic expect_active(input logic [1:0] care, input logic [1:0] value);
		act_care = care;
		act_exp = value;
	endtask

	task automatic start_span();
		lo1 = 64;
		hi1 = 0;
		lo2 = 64;
		hi2 = 0;
	endtask

	// both voices run at their start volume here, the envelope being frozen.
	task automatic check_span_model(input string msg);
		int v1;
		int v2;
		int base;
		v1 = nr12[7:4];
		v2 = nr22[7:4];
		base = 2 * snd_pkg::VOICE_IDLE; // the two dropped voice slots.
		compare_level({msg, " side 1 max"}, hi1,
			slot_level(nr51[0], v1, 1'b1) + slot_level(nr51[1], v2, 1'b1) + base);
		compare_level({msg, " side 1 min"}, lo1,
			slot_level(nr51[0], v1, 1'b0) + slot_level(nr51[1], v2, 1'b0) + base);
		compare_level({msg, " side 2 max"}, hi2,
			slot_level(nr51[4], v1, 1'b1) + slot_level(nr51[5], v2, 1'b1) + base);
		compare_level({msg, " side 2 min"}, lo2,
			slot_level(nr51[4], v1, 1'b0) + slot_level(nr51[5], v2, 1'b0) + base);
	endtask

	task automatic check_flat(input string msg, input int value);
		compare_level({msg, " side 1 max"}, hi1, value);
		compare_level({msg, " side 1 min"}, lo1, value);
		compare_level({msg, " side 2 max"}, hi2, value);
		compare_level({msg, " side 2 min"}, lo2, value);
	endtask

	task automatic check_peak_falls(input string msg);
		if (hi1 > peak)
			report_error($sformatf("%s rose to %0d from %0d", msg, hi1, peak));
		peak = hi1;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			master <= 1'b0;
			{nr11, nr12, nr14, nr21, nr22, nr24, nr51} <= '0;
			rd_pending <= 1'b0;
		end else begin
			rd_pending <= read;
			if (read) begin
				rd_adr  <= adr;
				rd_exp  <= expected_read(adr);
				rd_mask <= (adr == snd_pkg::NR52) ? {6'h3f, act_care} : 8'hff;
			end
			if (write && master) begin
				case (adr)
				snd_pkg::NR11: nr11 <= din;
				snd_pkg::NR12: nr12 <= din;
				snd_pkg::NR14: nr14 <= din;
				snd_pkg::NR21: nr21 <= din;
				snd_pkg::NR22: nr22 <= din;
				snd_pkg::NR24: nr24 <= din;
				snd_pkg::NR51: nr51 <= din;
				snd_pkg::NR52: master <= din[7];
				default: ;
				endcase
			end else if (write && adr == snd_pkg::NR52 && din[7]) begin
				master <= 1'b1; // switching on is all the unit accepts while off.
			end
		end
	end

	// outputs settle after the rising edge, so they are sampled on the falling one.
	always @(negedge clk) begin
		if (rd_pending) begin
			if ((dout & rd_mask) !== (rd_exp & rd_mask))
				report_error($sformatf("read of 0x%02h returned 0x%02h, expected 0x%02h",
					rd_adr, dout, rd_exp));
			reads_done++;
		end
		lo1 = (so1_level < lo1) ? so1_level : lo1;
		hi1 = (so1_level > hi1) ? so1_level : hi1;
		lo2 = (so2_level < lo2) ? so2_level : lo2;
		hi2 = (so2_level > hi2) ? so2_level : hi2;
	end

endmodule

// File: test/snd_tb.sv
module snd_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                        clk;
	logic                        reset;
	logic [snd_pkg::ADR_W-1:0]   adr;
	logic [snd_pkg::DATA_W-1:0]  din;
	logic                        read;
	logic                        write;
	logic [snd_pkg::DATA_W-1:0]  dout;
	logic [snd_pkg::LEVEL_W-1:0] so1_level;
	logic [snd_pkg::LEVEL_W-1:0] so2_level;
	logic [31:0]                 lfsr_state = 32'h753b;
	int                          chk_fails;

	always #10 clk = ~clk;

	lr35902_snd DUT (.clk, .reset, .adr, .din, .read, .write, .dout, .so1_level, .so2_level);

	snd_monitor u_mon (.clk, .reset, .adr, .din, .read, .write, .dout, .so1_level, .so2_level);

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [5:0] kept_adr(input int i);
		case (i)
		0:       return snd_pkg::NR11;
		1:       return snd_pkg::NR12;
		2:       return snd_pkg::NR13;
		3:       return snd_pkg::NR14;
		4:       return snd_pkg::NR21;
		5:       return snd_pkg::NR22;
		6:       return snd_pkg::NR23;
		7:       return snd_pkg::NR24;
		default: return snd_pkg::NR51;
		endcase
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic reg_write(input logic [5:0] a, input logic [7:0] d);
		@(negedge clk);
		adr = a;
		din = d;
		write = 1'b1;
		@(negedge clk);
		write = 1'b0;
	endtask

	task automatic reg_read(input logic [5:0] a);
		int seen;
		int waited;
		seen = u_mon.reads_done;
		@(negedge clk);
		adr = a;
		read = 1'b1;
		@(negedge clk);
		read = 1'b0;
		waited = 0;
		while (u_mon.reads_done == seen && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		if (u_mon.reads_done == seen)
			u_mon.timeout_seen($sformatf("no read response for 0x%02h within 4 cycles", a));
	endtask

	task automatic write_then_read_all();
		for (int i = 0; i < 9; i++) begin
			reg_write(kept_adr(i), rand_bits(8));
			reg_read(kept_adr(i));
		end
	endtask

	task automatic routing_round();
		logic [1:0] duty;
		duty = rand_bits(2);
		if (duty == 2'd0)
			duty = 2'd3;
		reg_write(snd_pkg::NR51, rand_bits(8));
		reg_write(snd_pkg::NR11, {duty, 6'(rand_bits(6))}); // same duty keeps the voices in step.
		reg_write(snd_pkg::NR12, {4'(rand_bits(4)), 4'h0});
		reg_write(snd_pkg::NR13, 8'hff);
		reg_write(snd_pkg::NR21, {duty, 6'(rand_bits(6))});
		reg_write(snd_pkg::NR22, {4'(rand_bits(4)), 4'h0});
		reg_write(snd_pkg::NR23, 8'hff);
		reg_write(snd_pkg::NR14, 8'h87);
		reg_write(snd_pkg::NR24, 8'h87);
		idle(8);
		u_mon.start_span();
		idle(64);
		u_mon.check_span_model("routed levels");
	endtask

	task automatic envelope_test();
		reg_write(snd_pkg::NR51, 8'h01); // voice 1 on side 1 only.
		reg_write(snd_pkg::NR11, 8'h80);
		reg_write(snd_pkg::NR12, 8'hf1);
		reg_write(snd_pkg::NR13, 8'hff);
		reg_write(snd_pkg::NR14, 8'h87);
		idle(8);
		for (int w = 0; w < 17; w++) begin
			u_mon.start_span();
			idle(65536);
			u_mon.check_peak_falls($sformatf("peak of window %0d", w));
		end
		u_mon.start_span();
		idle(64);
		u_mon.check_flat("decayed voice", 32);
		reg_write(snd_pkg::NR12, 8'hf9);
		reg_write(snd_pkg::NR14, 8'h87);
		idle(8);
		u_mon.start_span();
		idle(2 * 65536);
		u_mon.check_span_model("increasing envelope");
	endtask

	task automatic length_test();
		int len;
		len = 60 + rand_bits(2);
		reg_write(snd_pkg::NR11, {2'b10, 6'(len)});
		reg_write(snd_pkg::NR12, 8'hf0);
		reg_write(snd_pkg::NR14, 8'hc7);
		u_mon.expect_active(2'b01, 2'b01);
		idle((64 - len) * 16384 - 8);
		reg_read(snd_pkg::NR52);
		u_mon.expect_active(2'b01, 2'b00);
		idle(2 * 16384);
		reg_read(snd_pkg::NR52);
		u_mon.expect_active(2'b00, 2'b00);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		adr = '0;
		din = '0;
		read = 1'b0;
		write = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		u_mon.start_test("register read-back");
		reg_write(snd_pkg::NR52, 8'h80);
		write_then_read_all();
		reg_read(snd_pkg::NR52);
		for (int i = 0; i < 8; i++)
			reg_read(rand_bits(6));
		u_mon.end_test();

		u_mon.start_test("master gating");
		reg_write(snd_pkg::NR52, {1'b0, 7'(rand_bits(7))});
		reg_read(snd_pkg::NR52);
		idle(4);
		u_mon.start_span();
		idle(16);
		u_mon.check_flat("levels while off", snd_pkg::MIX_IDLE);
		write_then_read_all();
		reg_write(snd_pkg::NR52, {1'b1, 7'(rand_bits(7))});
		reg_read(snd_pkg::NR52);
		u_mon.end_test();

		u_mon.start_test("routing and level rule");
		repeat (4) routing_round();
		u_mon.end_test();

		u_mon.start_test("envelope");
		envelope_test();
		u_mon.end_test();

		u_mon.start_test("length expiry");
		length_test();
		u_mon.end_test();

		chk_fails = DUT.u_chk.fail_count;
		$display("tests run %0d, passed %0d, failed %0d, assertion failures %0d",
			u_mon.tests_run, u_mon.tests_run - u_mon.tests_failed, u_mon.tests_failed,
			chk_fails);
		if (u_mon.tests_failed == 0 && chk_fails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
